// ==== logic/rv32_params.svh ====
`ifndef RV32_PARAMS_SVH
`define RV32_PARAMS_SVH

`define RV32_XLEN       32
`define RV32_REG_COUNT  32
`define RV32_REG_IDX_W  5
`define RV32_ALU_OP_W   4

`define RV32_OPC_OP     7'b0110011
`define RV32_OPC_OP_IMM 7'b0010011
`define RV32_OPC_LUI    7'b0110111

`define RV32_F7_BASE    7'b0000000
`define RV32_F7_ALT     7'b0100000    // sub, sra, srai
`define RV32_F7_MULDIV  7'b0000001

`define RV32_ALU_ADD    4'd0
`define RV32_ALU_SUB    4'd1
`define RV32_ALU_SLL    4'd2
`define RV32_ALU_SLT    4'd3
`define RV32_ALU_SLTU   4'd4
`define RV32_ALU_XOR    4'd5
`define RV32_ALU_SRL    4'd6
`define RV32_ALU_SRA    4'd7
`define RV32_ALU_OR     4'd8
`define RV32_ALU_AND    4'd9
`define RV32_ALU_MUL    4'd10
`define RV32_ALU_PASS_B 4'd11   // lui

`endif

// ==== logic/rv32_pkg.sv ====
`default_nettype none

`include "rv32_params.svh"

package rv32_pkg;

    typedef logic [`RV32_XLEN-1:0]      word_t;
    typedef logic [31:0]                inst_t;
    typedef logic [`RV32_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`RV32_ALU_OP_W-1:0]  alu_op_t;

endpackage : rv32_pkg

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv32_params.svh"

module decode_stage (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               inst_valid_i,
    input  wire rv32_pkg::inst_t    inst_i,
    input  wire rv32_pkg::word_t    rf_rs1_data_i,
    input  wire rv32_pkg::word_t    rf_rs2_data_i,
    input  wire logic               ex_comb_we_i,
    input  wire rv32_pkg::reg_idx_t ex_comb_rd_i,
    input  wire rv32_pkg::word_t    ex_comb_result_i,
    input  wire logic               ex_we_i,
    input  wire rv32_pkg::reg_idx_t ex_rd_i,
    input  wire rv32_pkg::word_t    ex_result_i,
    output rv32_pkg::reg_idx_t      rf_rs1_idx_o,
    output rv32_pkg::reg_idx_t      rf_rs2_idx_o,
    output logic                    dec_valid_o,
    output logic                    dec_we_o,
    output logic                    dec_illegal_o,
    output rv32_pkg::alu_op_t       dec_alu_op_o,
    output rv32_pkg::word_t         dec_op_a_o,
    output rv32_pkg::word_t         dec_op_b_o,
    output rv32_pkg::reg_idx_t      dec_rd_o
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    rv32_pkg::reg_idx_t rd;
    rv32_pkg::word_t    imm_i, imm_u;
    rv32_pkg::word_t    rs1_val, rs2_val, op_b;
    rv32_pkg::alu_op_t  base_op, alu_op;
    logic               illegal;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign rf_rs1_idx_o = inst_i[19:15];
    assign rf_rs2_idx_o = inst_i[24:20];

    assign imm_i = {{(`RV32_XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};

    // newest producer wins, x0 never forwards
    function automatic rv32_pkg::word_t fwd_operand(
        input rv32_pkg::reg_idx_t idx,
        input rv32_pkg::word_t    rf_data
    );
        rv32_pkg::word_t val;
        if (idx != '0 && ex_comb_we_i && ex_comb_rd_i == idx) begin
            val = ex_comb_result_i;
        end else if (idx != '0 && ex_we_i && ex_rd_i == idx) begin
            val = ex_result_i;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign rs1_val = fwd_operand(rf_rs1_idx_o, rf_rs1_data_i);
    assign rs2_val = fwd_operand(rf_rs2_idx_o, rf_rs2_data_i);

    always_comb begin
        case (funct3)
            3'b000:  base_op = `RV32_ALU_ADD;
            3'b001:  base_op = `RV32_ALU_SLL;
            3'b010:  base_op = `RV32_ALU_SLT;
            3'b011:  base_op = `RV32_ALU_SLTU;
            3'b100:  base_op = `RV32_ALU_XOR;
            3'b101:  base_op = `RV32_ALU_SRL;
            3'b110:  base_op = `RV32_ALU_OR;
            default: base_op = `RV32_ALU_AND;
        endcase
    end

    always_comb begin
        alu_op  = base_op;
        op_b    = rs2_val;
        illegal = 1'b0;
        case (opcode)
            `RV32_OPC_OP: begin
                if (funct7 == `RV32_F7_ALT) begin
                    if (funct3 == 3'b000) begin
                        alu_op = `RV32_ALU_SUB;
                    end else if (funct3 == 3'b101) begin
                        alu_op = `RV32_ALU_SRA;
                    end else begin
                        illegal = 1'b1;
                    end
                end else if (funct7 == `RV32_F7_MULDIV) begin
                    alu_op  = `RV32_ALU_MUL;
                    illegal = (funct3 != 3'b000);    // only mul, no div/rem/mulh
                end else if (funct7 != `RV32_F7_BASE) begin
                    illegal = 1'b1;
                end
            end
            `RV32_OPC_OP_IMM: begin
                op_b = imm_i;    // shift amount sits in imm_i[4:0]
                if (funct3 == 3'b001) begin
                    illegal = (funct7 != `RV32_F7_BASE);
                end else if (funct3 == 3'b101) begin
                    if (funct7 == `RV32_F7_ALT) begin
                        alu_op = `RV32_ALU_SRA;
                    end else if (funct7 != `RV32_F7_BASE) begin
                        illegal = 1'b1;
                    end
                end
            end
            `RV32_OPC_LUI: begin
                alu_op = `RV32_ALU_PASS_B;
                op_b   = imm_u;
            end
            default: illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid_o   <= 1'b0;
            dec_we_o      <= 1'b0;
            dec_illegal_o <= 1'b0;
        end else begin
            dec_valid_o   <= inst_valid_i;
            dec_we_o      <= inst_valid_i && !illegal && rd != '0;
            dec_illegal_o <= inst_valid_i && illegal;
        end
    end

    always_ff @(posedge clk) begin
        dec_alu_op_o <= alu_op;
        dec_op_a_o   <= rs1_val;
        dec_op_b_o   <= op_b;
        dec_rd_o     <= rd;
    end

endmodule : decode_stage

`default_nettype wire

// ==== logic/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv32_params.svh"

module execute_stage (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               dec_valid_i,
    input  wire logic               dec_we_i,
    input  wire logic               dec_illegal_i,
    input  wire rv32_pkg::alu_op_t  dec_alu_op_i,
    input  wire rv32_pkg::word_t    dec_op_a_i,
    input  wire rv32_pkg::word_t    dec_op_b_i,
    input  wire rv32_pkg::reg_idx_t dec_rd_i,
    output logic                    ex_comb_we_o,
    output rv32_pkg::reg_idx_t      ex_comb_rd_o,
    output rv32_pkg::word_t         ex_comb_result_o,
    output logic                    ex_valid_o,
    output logic                    ex_we_o,
    output logic                    ex_illegal_o,
    output rv32_pkg::reg_idx_t      ex_rd_o,
    output rv32_pkg::word_t         ex_result_o
);

    rv32_pkg::word_t result;
    logic [4:0]      shamt;
    logic            lt_s, lt_u;

    assign shamt = dec_op_b_i[4:0];
    assign lt_s  = $signed(dec_op_a_i) < $signed(dec_op_b_i);
    assign lt_u  = dec_op_a_i < dec_op_b_i;

    always_comb begin
        case (dec_alu_op_i)
            `RV32_ALU_ADD:    result = dec_op_a_i + dec_op_b_i;
            `RV32_ALU_SUB:    result = dec_op_a_i - dec_op_b_i;
            `RV32_ALU_SLL:    result = dec_op_a_i << shamt;
            `RV32_ALU_SLT:    result = {{(`RV32_XLEN-1){1'b0}}, lt_s};
            `RV32_ALU_SLTU:   result = {{(`RV32_XLEN-1){1'b0}}, lt_u};
            `RV32_ALU_XOR:    result = dec_op_a_i ^ dec_op_b_i;
            `RV32_ALU_SRL:    result = dec_op_a_i >> shamt;
            `RV32_ALU_SRA:    result = $signed(dec_op_a_i) >>> shamt;
            `RV32_ALU_OR:     result = dec_op_a_i | dec_op_b_i;
            `RV32_ALU_AND:    result = dec_op_a_i & dec_op_b_i;
            `RV32_ALU_MUL:    result = dec_op_a_i * dec_op_b_i;   // low word only
            `RV32_ALU_PASS_B: result = dec_op_b_i;
            default:          result = '0;
        endcase
    end

    // same-cycle forwarding back to decode
    assign ex_comb_we_o     = dec_we_i;
    assign ex_comb_rd_o     = dec_rd_i;
    assign ex_comb_result_o = result;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid_o   <= 1'b0;
            ex_we_o      <= 1'b0;
            ex_illegal_o <= 1'b0;
        end else begin
            ex_valid_o   <= dec_valid_i;
            ex_we_o      <= dec_we_i;
            ex_illegal_o <= dec_illegal_i;
        end
    end

    always_ff @(posedge clk) begin
        ex_rd_o     <= dec_rd_i;
        ex_result_o <= result;
    end

endmodule : execute_stage

`default_nettype wire

// ==== logic/result_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv32_params.svh"

module result_stage (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               ex_valid_i,
    input  wire logic               ex_we_i,
    input  wire logic               ex_illegal_i,
    input  wire rv32_pkg::reg_idx_t ex_rd_i,
    input  wire rv32_pkg::word_t    ex_result_i,
    input  wire rv32_pkg::reg_idx_t rf_rs1_idx_i,
    input  wire rv32_pkg::reg_idx_t rf_rs2_idx_i,
    output rv32_pkg::word_t         rf_rs1_data_o,
    output rv32_pkg::word_t         rf_rs2_data_o,
    output logic                    wb_valid_o,
    output rv32_pkg::reg_idx_t      wb_rd_o,
    output rv32_pkg::word_t         wb_data_o,
    output logic                    illegal_o
);

    rv32_pkg::word_t regs [1:`RV32_REG_COUNT-1];   // x0 is not stored

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `RV32_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (ex_we_i && ex_rd_i != '0) begin
            regs[ex_rd_i] <= ex_result_i;
        end
    end

    assign rf_rs1_data_o = (rf_rs1_idx_i == '0) ? '0 : regs[rf_rs1_idx_i];
    assign rf_rs2_data_o = (rf_rs2_idx_i == '0) ? '0 : regs[rf_rs2_idx_i];

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
            illegal_o  <= 1'b0;
        end else begin
            wb_valid_o <= ex_valid_i && ex_we_i;
            illegal_o  <= ex_valid_i && ex_illegal_i;
        end
    end

    // same edge as the register write
    always_ff @(posedge clk) begin
        wb_rd_o   <= ex_rd_i;
        wb_data_o <= ex_result_i;
    end

endmodule : result_stage

`default_nettype wire

// ==== logic/rv32_int_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv32_int_core (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               inst_valid_i,
    input  wire rv32_pkg::inst_t    inst_i,
    output logic                    wb_valid_o,
    output rv32_pkg::reg_idx_t      wb_rd_o,
    output rv32_pkg::word_t         wb_data_o,
    output logic                    illegal_o
);

    rv32_pkg::reg_idx_t rf_rs1_idx, rf_rs2_idx;
    rv32_pkg::word_t    rf_rs1_data, rf_rs2_data;

    logic               dec_valid, dec_we, dec_illegal;
    rv32_pkg::alu_op_t  dec_alu_op;
    rv32_pkg::word_t    dec_op_a, dec_op_b;
    rv32_pkg::reg_idx_t dec_rd;

    logic               ex_comb_we;     // result still being computed
    rv32_pkg::reg_idx_t ex_comb_rd;
    rv32_pkg::word_t    ex_comb_result;

    logic               ex_valid, ex_we, ex_illegal;
    rv32_pkg::reg_idx_t ex_rd;
    rv32_pkg::word_t    ex_result;

    decode_stage decode_i (
        .clk(clk), .rst(rst),
        .inst_valid_i(inst_valid_i), .inst_i(inst_i),
        .rf_rs1_data_i(rf_rs1_data), .rf_rs2_data_i(rf_rs2_data),
        .ex_comb_we_i(ex_comb_we), .ex_comb_rd_i(ex_comb_rd),
        .ex_comb_result_i(ex_comb_result),
        .ex_we_i(ex_we), .ex_rd_i(ex_rd), .ex_result_i(ex_result),
        .rf_rs1_idx_o(rf_rs1_idx), .rf_rs2_idx_o(rf_rs2_idx),
        .dec_valid_o(dec_valid), .dec_we_o(dec_we), .dec_illegal_o(dec_illegal),
        .dec_alu_op_o(dec_alu_op), .dec_op_a_o(dec_op_a), .dec_op_b_o(dec_op_b),
        .dec_rd_o(dec_rd)
    );

    execute_stage execute_i (
        .clk(clk), .rst(rst),
        .dec_valid_i(dec_valid), .dec_we_i(dec_we), .dec_illegal_i(dec_illegal),
        .dec_alu_op_i(dec_alu_op), .dec_op_a_i(dec_op_a), .dec_op_b_i(dec_op_b),
        .dec_rd_i(dec_rd),
        .ex_comb_we_o(ex_comb_we), .ex_comb_rd_o(ex_comb_rd),
        .ex_comb_result_o(ex_comb_result),
        .ex_valid_o(ex_valid), .ex_we_o(ex_we), .ex_illegal_o(ex_illegal),
        .ex_rd_o(ex_rd), .ex_result_o(ex_result)
    );

    result_stage result_i (
        .clk(clk), .rst(rst),
        .ex_valid_i(ex_valid), .ex_we_i(ex_we), .ex_illegal_i(ex_illegal),
        .ex_rd_i(ex_rd), .ex_result_i(ex_result),
        .rf_rs1_idx_i(rf_rs1_idx), .rf_rs2_idx_i(rf_rs2_idx),
        .rf_rs1_data_o(rf_rs1_data), .rf_rs2_data_o(rf_rs2_data),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o),
        .illegal_o(illegal_o)
    );

endmodule : rv32_int_core

`default_nettype wire

// ==== verification/rv32_int_core_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv32_int_core_sva (
    input wire logic               clk,
    input wire logic               rst,
    input wire logic               inst_valid_i,
    input wire logic               wb_valid_i,
    input wire rv32_pkg::reg_idx_t wb_rd_i,
    input wire logic               illegal_i
);

    int fail_count = 0;

    one_strobe_a: assert property (@(posedge clk) disable iff (rst)
        !(wb_valid_i && illegal_i))
        else begin
            fail_count++;
            $error("write-back and illegal strobes are high together");
        end

    wb_rd_nonzero_a: assert property (@(posedge clk) disable iff (rst)
        wb_valid_i |-> wb_rd_i != '0)
        else begin
            fail_count++;
            $error("write-back strobe names register x0");
        end

    // fixed three-cycle latency
    strobe_source_a: assert property (@(posedge clk) disable iff (rst)
        (wb_valid_i || illegal_i) |-> $past(inst_valid_i, 3))
        else begin
            fail_count++;
            $error("output strobe without an instruction three cycles earlier");
        end

    reset_quiet_a: assert property (@(posedge clk)
        rst |=> !wb_valid_i && !illegal_i)
        else begin
            fail_count++;
            $error("output strobe high during reset");
        end

endmodule : rv32_int_core_sva

bind rv32_int_core rv32_int_core_sva sva_i (
    .clk(clk),
    .rst(rst),
    .inst_valid_i(inst_valid_i),
    .wb_valid_i(wb_valid_o),
    .wb_rd_i(wb_rd_o),
    .illegal_i(illegal_o)
);

`default_nettype wire

// ==== verification/rv32_int_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv32_int_core_tb;

    localparam int reset_cycles = 8;
    localparam int max_entries  = 64;
    localparam int max_gap      = 3;
    localparam int latency      = 3;
    localparam int kind_none    = 0;
    localparam int kind_write   = 1;
    localparam int kind_illegal = 2;

    logic               clk;
    logic               rst;
    logic               inst_valid_i;
    rv32_pkg::inst_t    inst_i;
    logic               wb_valid_o;
    rv32_pkg::reg_idx_t wb_rd_o;
    rv32_pkg::word_t    wb_data_o;
    logic               illegal_o;

    logic [31:0] stim_mem [0:4*max_entries-1];    // inst, kind, rd, data per entry
    int          n_entries;
    int          timeout_limit;
    int          cycle;
    int          n_checks;
    int          n_errors;
    logic [31:0] lfsr_state;

    // expectations in issue order
    int                 due_q[$];
    int                 kind_q[$];
    rv32_pkg::reg_idx_t rd_q[$];
    rv32_pkg::word_t    data_q[$];

    rv32_int_core dut_i (
        .clk(clk),
        .rst(rst),
        .inst_valid_i(inst_valid_i),
        .inst_i(inst_i),
        .wb_valid_o(wb_valid_o),
        .wb_rd_o(wb_rd_o),
        .wb_data_o(wb_data_o),
        .illegal_o(illegal_o)
    );

    always #20 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    function automatic logic [31:0] fill_word(input int addr);
        return 32'hbad0_0000 ^ addr;
    endfunction

    task automatic pick_gap(output int gap);
        logic [1:0] bits;
        lfsr_state = lfsr_next(lfsr_state);
        bits[0]    = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        bits[1]    = lfsr_state[0];
        gap        = bits;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("** Error at %0d ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic issue_entry(input int idx);
        int kind;
        kind = kind_none;
        if (stim_mem[4*idx+1] > kind_illegal) begin
            n_errors++;
            $display("Stimulus entry %0d has an unknown kind %0h", idx, stim_mem[4*idx+1]);
        end else begin
            kind = stim_mem[4*idx+1];
        end
        inst_valid_i = 1'b1;
        inst_i       = stim_mem[4*idx];
        due_q.push_back(cycle + latency);
        kind_q.push_back(kind);
        rd_q.push_back(stim_mem[4*idx+2][4:0]);
        data_q.push_back(stim_mem[4*idx+3]);
    endtask

    task automatic report_counts();
        $display("checks: %0d, mismatches and other errors: %0d, assertion failures: %0d",
                 n_checks, n_errors, dut_i.sva_i.fail_count);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            report_counts();
            $display("Test FAILED");
            $finish;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin : check_outputs
        int                 exp_kind;
        rv32_pkg::reg_idx_t exp_rd;
        rv32_pkg::word_t    exp_data;
        exp_kind = kind_none;
        exp_rd   = '0;
        exp_data = '0;
        if (due_q.size() != 0 && due_q[0] == cycle) begin
            void'(due_q.pop_front());
            exp_kind = kind_q.pop_front();
            exp_rd   = rd_q.pop_front();
            exp_data = data_q.pop_front();
        end
        check_value("wb_valid_o", wb_valid_o, exp_kind == kind_write);
        check_value("illegal_o", illegal_o, exp_kind == kind_illegal);
        if (exp_kind == kind_write) begin
            check_value("wb_rd_o", wb_rd_o, exp_rd);
            check_value("wb_data_o", wb_data_o, exp_data);
        end
    end

    initial begin
        int gap;
        int idx;
        clk          = 1'b0;
        rst          = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        lfsr_state   = 32'hfd55_45f7;

        for (idx = 0; idx < 4*max_entries; idx++) begin
            stim_mem[idx] = fill_word(idx);
        end
        $readmemh("verification/rv32_int_core_stim.txt", stim_mem);
        n_entries = 0;
        while (n_entries < max_entries &&
               stim_mem[4*n_entries+1] !== fill_word(4*n_entries+1)) begin
            n_entries++;
        end
        timeout_limit = reset_cycles + n_entries * (max_gap + 1) + 20;
        if (n_entries == 0) begin
            n_errors++;
            $display("No stimulus entries could be read from the data file");
        end

        repeat (reset_cycles) @(posedge clk);
        #2;
        rst = 1'b0;

        for (idx = 0; idx < n_entries; idx++) begin
            issue_entry(idx);
            @(posedge clk);
            #2;
            inst_valid_i = 1'b0;
            inst_i       = '0;
            pick_gap(gap);
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
        end

        while (due_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);    // no stray strobes after the last result

        report_counts();
        if (n_errors == 0 && dut_i.sva_i.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : rv32_int_core_tb

`default_nettype wire

// ==== verification/rv32_int_core_stim.txt ====
// columns are instruction word, expected kind, expected rd, expected data
// kind 0 means no strobe, 1 a write-back, 2 an illegal strobe
003100B3 1 01 00000000  // add x1, x2, x3 on unwritten sources
00500093 1 01 00000005  // addi x1, x0, 5
FFD00113 1 02 FFFFFFFD  // addi x2, x0, -3
002081B3 1 03 00000002  // add x3, x1, x2
40208233 1 04 00000008  // sub x4, x1, x2
001122B3 1 05 00000001  // slt x5, x2, x1
00113333 1 06 00000000  // sltu x6, x2, x1
800003B7 1 07 80000000  // lui x7, 0x80000
0013A433 1 08 00000001  // slt x8, x7, x1
0070B4B3 1 09 00000001  // sltu x9, x1, x7
4013D533 1 0A FC000000  // sra x10, x7, x1
0013D5B3 1 0B 04000000  // srl x11, x7, x1
00111633 1 0C FFFFFFA0  // sll x12, x2, x1
0020C6B3 1 0D FFFFFFF8  // xor x13, x1, x2
0020E733 1 0E FFFFFFFD  // or x14, x1, x2
0020F7B3 1 0F 00000005  // and x15, x1, x2
FFF14813 1 10 00000002  // xori x16, x2, -1
FFE12893 1 11 00000001  // slti x17, x2, -2
FFF0B913 1 12 00000001  // sltiu x18, x1, -1
7F017993 1 13 000007F0  // andi x19, x2, 0x7f0
8000EA13 1 14 FFFFF805  // ori x20, x1, -2048
01F09A93 1 15 80000000  // slli x21, x1, 31
404ADB13 1 16 F8000000  // srai x22, x21, 4
004ADB93 1 17 08000000  // srli x23, x21, 4
02110C33 1 18 FFFFFFF1  // mul x24, x2, x1
02210CB3 1 19 00000009  // mul x25, x2, x2
02738D33 1 1A 00000000  // mul x26, x7, x7
02DA0DB3 1 1B 00003FD8  // mul x27, x20, x13
00108093 1 01 00000006  // addi x1, x1, 1
00108093 1 01 00000007  // addi x1, x1, 1
001080B3 1 01 0000000E  // add x1, x1, x1
40208133 1 02 00000011  // sub x2, x1, x2
022080B3 1 01 000000EE  // mul x1, x1, x2
00708013 0 00 00000000  // addi x0, x1, 7
00100E33 1 1C 000000EE  // add x28, x0, x1
0220C1B3 2 03 00000000  // div x3, x1, x2
0000A203 2 04 00000000  // lw x4, 0(x1)
00208463 2 08 00000000  // beq x1, x2, 8
004182B3 1 05 0000000A  // add x5, x3, x4 sees old x3 and x4
4020C6B3 2 0D 00000000  // xor with funct7 0x20
0006E333 1 06 FFFFFFF8  // or x6, x13, x0
4106DF33 1 1E FFFFFFFE  // sra x30, x13, x16
02209FB3 2 1F 00000000  // mulh x31, x1, x2
01EF8FB3 1 1F FFFFFFFE  // add x31, x31, x30

// ==== rv32_int_core.f ====
+incdir+logic
logic/rv32_pkg.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/rv32_int_core.sv
verification/rv32_int_core_sva.sv
verification/rv32_int_core_tb.sv
